/* build.f */
src/chip_pkg.sv
src/sq_regs.sv
src/note_fx.sv
src/tone_gen.sv
src/envelope_ctrl.sv
src/sq_channel.sv
sim/sq_channel_sva.sv
sim/sq_channel_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the sq_channel testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module sq_channel_tb -f build.f -o sim_tb \
	&& ./obj_dir/sim_tb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "SIMULATION PASSED" sim.log 2>/dev/null && exit 0 || exit 1

/* sim/sq_channel_sva.sv */
`timescale 1ns/10ps
`default_nettype none

module sq_channel_sva
(
	input wire                        clk50mhz,
	input wire                        rst_n,
	input wire                        wb_cyc,
	input wire                        wb_stb,
	input wire                        wb_ack,
	input wire [chip_pkg::VOL_W-1:0]  volume,
	input wire [chip_pkg::VOL_W-1:0]  wave_out
);

	// ack is a single cycle pulse
	ack_one_cycle: assert property (@(posedge clk50mhz) disable iff (!rst_n)
		wb_ack |=> !wb_ack)
		else $error("wb_ack held high for more than one cycle");

	// ack only answers a request seen on the previous edge
	ack_after_req: assert property (@(posedge clk50mhz) disable iff (!rst_n)
		wb_ack |-> $past(wb_cyc && wb_stb))
		else $error("wb_ack raised without cyc and stb");

	// silent envelope means silent output
	silent_out: assert property (@(posedge clk50mhz) disable iff (!rst_n)
		(volume == '0) |-> (wave_out == '0))
		else $error("wave_out nonzero while volume is zero");

	// sequencer only gates the level, never scales it up
	out_le_vol: assert property (@(posedge clk50mhz) disable iff (!rst_n)
		wave_out <= volume)
		else $error("wave_out above envelope volume");

endmodule

bind sq_channel sq_channel_sva u_sva (
	.clk50mhz (clk50mhz),
	.rst_n    (rst_n),
	.wb_cyc   (wb_cyc),
	.wb_stb   (wb_stb),
	.wb_ack   (wb_ack),
	.volume   (volume),
	.wave_out (wave_out)
);

`default_nettype wire

/* sim/sq_channel_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module sq_channel_tb;

	localparam int MAX_CYCLES = 60000;  // ~12 phases of 40 ticks x 64 cycles, plus margin

	logic       clk50mhz = 1'b0;
	logic       rst_n    = 1'b0;
	logic       wb_cyc   = 1'b0;
	logic       wb_stb   = 1'b0;
	logic       wb_we    = 1'b0;
	logic [1:0] wb_adr   = 2'd0;
	logic [7:0] wb_dat_w = 8'd0;
	wire  [7:0] wb_dat_r;
	wire        wb_ack;
	wire  [3:0] wave_out;
	int         errors   = 0;
	int         cycles   = 0;

	sq_channel #(.TICK_DIV(64), .PRESCALE(1)) u_dut (
		.clk50mhz (clk50mhz), .rst_n (rst_n), .wb_cyc (wb_cyc), .wb_stb (wb_stb),
		.wb_we (wb_we), .wb_adr (wb_adr), .wb_dat_w (wb_dat_w),
		.wb_dat_r (wb_dat_r), .wb_ack (wb_ack), .wave_out (wave_out)
	);

	always #10 clk50mhz = ~clk50mhz;  // 50 MHz

	always @(posedge clk50mhz)
	begin
		cycles <= cycles + 1;
		if (cycles == MAX_CYCLES)
		begin
			$display("run timed out after %0d cycles", cycles);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	// octave 0 table shifted by octave, in cycles since prescale is 1
	function automatic int step_len(input int note);
		return int'(chip_pkg::PERIOD_BASE[note % 12]) >> (note / 12);
	endfunction

	task automatic bus_xfer(input logic we, input logic [1:0] adr, input logic [7:0] wd,
	                        output logic [7:0] rd);
		int waits;
		waits = 0;
		@(posedge clk50mhz);
		#1;
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = adr;
		wb_dat_w = wd;
		@(posedge clk50mhz);
		@(negedge clk50mhz);
		while (!wb_ack && waits < 8)
		begin
			waits++;
			@(negedge clk50mhz);
		end
		if (!wb_ack)
		begin
			$display("bus transfer to address %0d got no ack within 8 cycles", adr);
			errors++;
		end
		assert (waits == 0) else begin
			$display("[FAIL] %0t ack came %0d cycles late", $time, waits);
			errors++;
		end
		rd = wb_dat_r;  // valid while ack high
		@(posedge clk50mhz);
		#1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
	endtask

	task automatic reg_write(input logic [1:0] adr, input logic [7:0] wd);
		logic [7:0] dummy;
		bus_xfer(1'b1, adr, wd, dummy);
	endtask

	task automatic check_read(input logic [1:0] adr, input logic [7:0] exp);
		logic [7:0] rd;
		bus_xfer(1'b0, adr, 8'h00, rd);
		assert (rd == exp) else begin
			$display("[FAIL] %0t reg %0d read %h, expected %h", $time, adr, rd, exp);
			errors++;
		end
	endtask

	// skip to the first sample of a fresh high run, on falling edges
	task automatic wait_rise();
		@(negedge clk50mhz);
		while (wave_out != 4'd0) @(negedge clk50mhz);
		while (wave_out == 4'd0) @(negedge clk50mhz);
	endtask

	// one high run and the low run after it, from its first high sample
	// returns on the first high sample of the next run
	task automatic measure_run(output int hi, output int lo, output logic [3:0] lvl);
		hi  = 0;
		lo  = 0;
		lvl = wave_out;
		while (wave_out != 4'd0)
		begin
			hi++;
			@(negedge clk50mhz);
		end
		while (wave_out == 4'd0)
		begin
			lo++;
			@(negedge clk50mhz);
		end
	endtask

	task automatic check_pitch(input int note, input int duty);
		int hi, lo, len, nhigh;
		logic [3:0] lvl;
		nhigh = (duty == 0) ? 1 : (duty == 1) ? 2 : (duty == 2) ? 4 : 6;
		len   = step_len(note);
		reg_write(chip_pkg::REG_FX, 8'(duty << 2));
		reg_write(chip_pkg::REG_NOTE, 8'(note));
		wait_rise();
		repeat (2) measure_run(hi, lo, lvl);  // let the new length reach every step
		measure_run(hi, lo, lvl);
		assert (hi == nhigh * len && lo == (8 - nhigh) * len && lvl == 4'd15) else begin
			$display("[FAIL] %0t note %0d duty %0d hi %0d lo %0d lvl %0d", $time, note, duty,
			         hi, lo, lvl);
			errors++;
		end
	endtask

	initial
	begin
		int hi, lo, vol, prev, idx, last, done, base;
		logic [3:0] lvl;
		logic [7:0] rd;
		bit peak, up_seen, dn_seen, mid_seen, ramp_seen;
		repeat (3) @(posedge clk50mhz);
		#1 rst_n = 1'b1;

		// register access, status first while still idle
		reg_write(chip_pkg::REG_STATUS, 8'hff);
		check_read(chip_pkg::REG_STATUS, 8'h00);
		reg_write(chip_pkg::REG_ENV, 8'hdb);
		check_read(chip_pkg::REG_ENV, 8'h5b);   // bit 7 unused
		reg_write(chip_pkg::REG_FX, 8'ha4);
		check_read(chip_pkg::REG_FX, 8'ha4);
		reg_write(chip_pkg::REG_NOTE, 8'h2a);
		check_read(chip_pkg::REG_NOTE, 8'h2a);
		check_read(chip_pkg::REG_ENV, 8'h5b);   // untouched by later writes
		check_read(chip_pkg::REG_FX, 8'ha4);

		// plain tone, full level held forever
		reg_write(chip_pkg::REG_ENV, 8'h00);
		check_pitch(36, 0);
		check_pitch(50, 2);
		check_pitch(63, 3);

		// envelope: attack 2, decay 1, length 2
		reg_write(chip_pkg::REG_ENV, 8'h26);
		reg_write(chip_pkg::REG_NOTE, 8'd36);
		prev = 0;
		peak = 0;
		done = 0;
		while (!done)
		begin
			bus_xfer(1'b0, chip_pkg::REG_STATUS, 8'h00, rd);
			vol = rd[3:0];
			assert (peak ? vol <= prev : vol >= prev) else begin
				$display("[FAIL] %0t volume %0d after %0d breaks monotonic envelope", $time,
				         vol, prev);
				errors++;
			end
			if (vol == 15) peak = 1;
			if (peak && !rd[7]) done = 1;  // envelope finished
			prev = vol;
		end
		assert (vol == 0 && peak) else begin
			$display("[FAIL] %0t envelope ended at %0d, peak seen %0d", $time, vol, peak);
			errors++;
		end

		// portamento 40 -> 44, one high step per period
		reg_write(chip_pkg::REG_ENV, 8'h00);
		reg_write(chip_pkg::REG_FX, 8'h00);
		reg_write(chip_pkg::REG_NOTE, 8'd40);
		wait_rise();
		repeat (2) measure_run(hi, lo, lvl);
		reg_write(chip_pkg::REG_FX, 8'h31);   // speed 3, duty 0, porta
		reg_write(chip_pkg::REG_NOTE, 8'd44);
		wait_rise();
		last     = 0;
		done     = 0;
		mid_seen = 0;
		for (int r = 0; r < 16 && done < 2; r++)
		begin
			measure_run(hi, lo, lvl);
			idx = -1;
			for (int n = 0; n <= 4; n++)
				if (hi == step_len(40 + n)) idx = n;
			assert (idx >= last) else begin
				$display("[FAIL] %0t porta step %0d out of order", $time, hi);
				errors++;
			end
			if (idx >= 0) last = idx;
			if (idx > 0 && idx < 4) mid_seen = 1;  // somewhere in 41..43
			if (idx == 4) done++;
		end
		assert (done == 2) else begin
			$display("[FAIL] %0t porta never settled on note 44", $time);
			errors++;
		end
		assert (mid_seen) else begin
			$display("[FAIL] %0t porta reached note 44 without an intermediate note", $time);
			errors++;
		end

		// vibrato depth 1 speed 3, duty 1, on note 60
		reg_write(chip_pkg::REG_FX, 8'h76);
		reg_write(chip_pkg::REG_NOTE, 8'd60);
		wait_rise();
		repeat (2) measure_run(hi, lo, lvl);
		base    = 2 * step_len(60);
		up_seen = 0;
		dn_seen = 0;
		repeat (12)
		begin
			measure_run(hi, lo, lvl);
			assert (hi == base || hi == base + 8 || hi == base - 8) else begin
				$display("[FAIL] %0t vibrato high run %0d, base %0d", $time, hi, base);
				errors++;
			end
			if (hi == base + 8) up_seen = 1;
			if (hi == base - 8) dn_seen = 1;
		end
		assert (up_seen && dn_seen) else begin
			$display("[FAIL] %0t vibrato did not swing both ways", $time);
			errors++;
		end

		// slide up from 56, one semitone per tick
		reg_write(chip_pkg::REG_FX, 8'h83);
		reg_write(chip_pkg::REG_NOTE, 8'd56);
		wait_rise();
		prev      = step_len(56);
		done      = 0;
		ramp_seen = 0;
		for (int r = 0; r < 30 && done < 3; r++)
		begin
			measure_run(hi, lo, lvl);
			assert (hi <= prev) else begin
				$display("[FAIL] %0t slide step grew from %0d to %0d", $time, prev, hi);
				errors++;
			end
			if (hi > step_len(63)) ramp_seen = 1;  // still below the top note
			if (hi == step_len(63)) done++;
			prev = hi;
		end
		assert (done == 3 && ramp_seen) else begin
			$display("[FAIL] %0t slide did not climb and stop at note 63", $time);
			errors++;
		end

		$display("checks done, errors: %0d", errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* src/chip_pkg.sv */
`default_nettype none

package chip_pkg;

	localparam int NOTE_W = 6;      // note = octave*12 + semitone, 0..63
	localparam int VOL_W  = 4;      // envelope level and output sample
	localparam int PER_W  = 16;     // step length in prescaled ticks
	localparam int OFS_W  = 5;      // signed vibrato offset, +-8 max

	// wishbone word addresses
	localparam logic [1:0] REG_NOTE   = 2'd0;
	localparam logic [1:0] REG_FX     = 2'd1;
	localparam logic [1:0] REG_ENV    = 2'd2;
	localparam logic [1:0] REG_STATUS = 2'd3; // read only

	// effect select, FX[1:0]
	localparam logic [1:0] FX_NONE    = 2'd0;
	localparam logic [1:0] FX_PORTA   = 2'd1;
	localparam logic [1:0] FX_VIBRATO = 2'd2;
	localparam logic [1:0] FX_SLIDE   = 2'd3;

	// octave 0 step lengths, C .. B
	// one step is 1/8 of the square period
	localparam logic [PER_W-1:0] PERIOD_BASE [12] = '{
		16'd747, 16'd705, 16'd665, 16'd628, 16'd593, 16'd559,
		16'd528, 16'd498, 16'd470, 16'd444, 16'd419, 16'd395
	};

	// FX[7:4], read differently by slide than by porta/vibrato
	typedef union packed
	{
		struct packed
		{
			logic [1:0] depth;  // vibrato swing, (depth+1)*2 ticks
			logic [1:0] speed;  // frame ticks per step, minus one
		} rate;
		struct packed
		{
			logic       dir;    // 1 = slide up
			logic [2:0] step;   // frame ticks per semitone, minus one
		} slide;
	} fx_opt_u;

endpackage

`default_nettype wire

/* src/envelope_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module envelope_ctrl
#(
	parameter int TICK_DIV = 833_333   // clocks per frame tick
)
(
	input  wire                           clk50mhz,
	input  wire                           rst_n,
	input  wire  [1:0]                    attack,
	input  wire  [1:0]                    decay,
	input  wire  [2:0]                    length,
	input  wire                           key_on,
	output logic                          frame_tick,
	output logic [chip_pkg::VOL_W-1:0]    volume,
	output logic                          env_active
);

	localparam int CNT_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;
	localparam logic [chip_pkg::VOL_W-1:0] VOL_MAX = '1;

	localparam logic [1:0] PH_IDLE = 2'd0;
	localparam logic [1:0] PH_ATK  = 2'd1;
	localparam logic [1:0] PH_HOLD = 2'd2;
	localparam logic [1:0] PH_DEC  = 2'd3;

	logic [CNT_W-1:0] div_cnt;
	logic [1:0]       phase;
	logic [1:0]       rate_cnt;   // ticks into the current attack/decay step
	logic [4:0]       hold_cnt;
	logic [4:0]       hold_len;

	assign hold_len = {length, 2'b00};  // length*4 ticks

	// free running from reset, key_on does not realign it
	always_ff @(posedge clk50mhz)
	begin
		if (!rst_n)
		begin
			div_cnt    <= '0;
			frame_tick <= 1'b0;
		end
		else if (div_cnt == CNT_W'(TICK_DIV - 1))
		begin
			div_cnt    <= '0;
			frame_tick <= 1'b1;
		end
		else
		begin
			div_cnt    <= div_cnt + 1'b1;
			frame_tick <= 1'b0;
		end
	end

	always_ff @(posedge clk50mhz)
	begin
		if (!rst_n)
		begin
			phase      <= PH_IDLE;
			volume     <= '0;
			env_active <= 1'b0;
			rate_cnt   <= 2'd0;
			hold_cnt   <= 5'd0;
		end
		else if (key_on)
		begin
			rate_cnt   <= 2'd0;
			hold_cnt   <= 5'd0;
			env_active <= 1'b1;
			if (attack == 2'd0)
			begin
				volume <= VOL_MAX;   // no attack, straight to full
				phase  <= PH_HOLD;
			end
			else
			begin
				volume <= '0;
				phase  <= PH_ATK;
			end
		end
		else if (frame_tick)
		begin
			case (phase)
				PH_ATK:
				begin
					if (rate_cnt + 2'd1 == attack)
					begin
						rate_cnt <= 2'd0;
						volume   <= volume + 1'b1;
						if (volume == VOL_MAX - 1'b1)
							phase <= PH_HOLD;
					end
					else
						rate_cnt <= rate_cnt + 2'd1;
				end
				PH_HOLD:
				begin
					// length 0 sustains until the next key_on
					if (length != 3'd0)
					begin
						if (hold_cnt + 5'd1 == hold_len)
						begin
							phase    <= PH_DEC;
							rate_cnt <= 2'd0;
						end
						else
							hold_cnt <= hold_cnt + 5'd1;
					end
				end
				PH_DEC:
				begin
					if (decay == 2'd0)
					begin
						volume     <= '0;   // hard cut
						env_active <= 1'b0;
						phase      <= PH_IDLE;
					end
					else if (rate_cnt + 2'd1 == decay)
					begin
						rate_cnt <= 2'd0;
						volume   <= volume - 1'b1;
						if (volume == chip_pkg::VOL_W'(1))
						begin
							env_active <= 1'b0;
							phase      <= PH_IDLE;
						end
					end
					else
						rate_cnt <= rate_cnt + 2'd1;
				end
				default: ;   // idle, wait for key_on
			endcase
		end
	end

endmodule

`default_nettype wire

/* src/note_fx.sv */
`timescale 1ns/10ps
`default_nettype none

module note_fx
(
	input  wire                                   clk50mhz,
	input  wire                                   rst_n,
	input  wire  [chip_pkg::NOTE_W-1:0]           target_note,
	input  wire  [1:0]                            fx_sel,
	input  wire  chip_pkg::fx_opt_u               fx_opt,
	input  wire                                   frame_tick,
	input  wire                                   key_on,
	output logic [chip_pkg::NOTE_W-1:0]           play_note,
	output logic signed [chip_pkg::OFS_W-1:0]     period_offset
);

	localparam logic [chip_pkg::NOTE_W-1:0] NOTE_MAX = '1;  // 63

	logic [1:0]                      fx_sel_q;   // previous effect, for change detect
	logic [2:0]                      rate_cnt;   // frame ticks since last effect step
	logic [2:0]                      rate_lim;
	logic                            vib_up;     // next vibrato swing goes positive
	logic signed [chip_pkg::OFS_W-1:0] vib_amp;
	logic                            restart;

	assign restart = key_on | (fx_sel != fx_sel_q);

	// slide reads a 3 bit rate, the others a 2 bit speed
	assign rate_lim = (fx_sel == chip_pkg::FX_SLIDE) ? fx_opt.slide.step
	                                                 : {1'b0, fx_opt.rate.speed};

	// (depth+1)*2, always positive
	assign vib_amp = {1'b0, {1'b0, fx_opt.rate.depth} + 3'd1, 1'b0};

	always_ff @(posedge clk50mhz)
	begin
		if (!rst_n)
		begin
			fx_sel_q      <= chip_pkg::FX_NONE;
			rate_cnt      <= '0;
			vib_up        <= 1'b1;
			play_note     <= '0;
			period_offset <= '0;
		end
		else
		begin
			fx_sel_q <= fx_sel;
			if (restart)
			begin
				rate_cnt      <= '0;
				vib_up        <= 1'b1;
				period_offset <= '0;
				// porta retarget keeps the old pitch and glides from it
				if (fx_sel != chip_pkg::FX_PORTA || fx_sel != fx_sel_q)
					play_note <= target_note;
			end
			else if (frame_tick)
			begin
				if (rate_cnt < rate_lim)
					rate_cnt <= rate_cnt + 3'd1;   // not yet time for a step
				else
				begin
					rate_cnt <= '0;
					case (fx_sel)
						chip_pkg::FX_NONE:
						begin
							play_note     <= target_note;
							period_offset <= '0;
						end
						chip_pkg::FX_PORTA:
						begin
							if (play_note < target_note)
								play_note <= play_note + 1'b1;
							else if (play_note > target_note)
								play_note <= play_note - 1'b1;
						end
						chip_pkg::FX_VIBRATO:
						begin
							play_note     <= target_note;
							period_offset <= vib_up ? vib_amp : -vib_amp;  // swing around base
							vib_up        <= ~vib_up;
						end
						chip_pkg::FX_SLIDE:
						begin
							if (fx_opt.slide.dir)
							begin
								if (play_note != NOTE_MAX)
									play_note <= play_note + 1'b1;   // up, stops at 63
							end
							else if (play_note != '0)
								play_note <= play_note - 1'b1;       // down, stops at 0
						end
					endcase
				end
			end
		end
	end

endmodule

`default_nettype wire

/* src/sq_channel.sv */
`timescale 1ns/10ps
`default_nettype none

module sq_channel
#(
	parameter int TICK_DIV = 833_333,  // ~60 Hz frame at 50 MHz
	parameter int PRESCALE = 512       // scales the period table to audio range
)
(
	input  wire                          clk50mhz,
	input  wire                          rst_n,
	input  wire                          wb_cyc,
	input  wire                          wb_stb,
	input  wire                          wb_we,
	input  wire  [1:0]                   wb_adr,
	input  wire  [7:0]                   wb_dat_w,
	output logic [7:0]                   wb_dat_r,
	output logic                         wb_ack,
	output logic [chip_pkg::VOL_W-1:0]   wave_out
);

	wire [chip_pkg::NOTE_W-1:0]        target_note;
	wire [1:0]                         fx_sel;
	wire chip_pkg::fx_opt_u            fx_opt;
	wire [1:0]                         duty;
	wire [1:0]                         attack;
	wire [1:0]                         decay;
	wire [2:0]                         length;
	wire                               key_on;     // pulse on each note write
	wire                               frame_tick;
	wire [chip_pkg::VOL_W-1:0]         volume;
	wire                               env_active;
	wire [chip_pkg::NOTE_W-1:0]        play_note;  // after effects
	wire signed [chip_pkg::OFS_W-1:0]  period_offset;

	sq_regs u_regs (
		.clk50mhz    (clk50mhz),
		.rst_n       (rst_n),
		.wb_cyc      (wb_cyc),
		.wb_stb      (wb_stb),
		.wb_we       (wb_we),
		.wb_adr      (wb_adr),
		.wb_dat_w    (wb_dat_w),
		.volume      (volume),
		.env_active  (env_active),
		.wb_dat_r    (wb_dat_r),
		.wb_ack      (wb_ack),
		.target_note (target_note),
		.fx_sel      (fx_sel),
		.fx_opt      (fx_opt),
		.duty        (duty),
		.attack      (attack),
		.decay       (decay),
		.length      (length),
		.key_on      (key_on)
	);

	envelope_ctrl #(.TICK_DIV(TICK_DIV)) u_env (
		.clk50mhz   (clk50mhz),
		.rst_n      (rst_n),
		.attack     (attack),
		.decay      (decay),
		.length     (length),
		.key_on     (key_on),
		.frame_tick (frame_tick),
		.volume     (volume),
		.env_active (env_active)
	);

	note_fx u_fx (
		.clk50mhz      (clk50mhz),
		.rst_n         (rst_n),
		.target_note   (target_note),
		.fx_sel        (fx_sel),
		.fx_opt        (fx_opt),
		.frame_tick    (frame_tick),
		.key_on        (key_on),
		.play_note     (play_note),
		.period_offset (period_offset)
	);

	tone_gen #(.PRESCALE(PRESCALE)) u_tone (
		.clk50mhz      (clk50mhz),
		.rst_n         (rst_n),
		.play_note     (play_note),
		.period_offset (period_offset),
		.duty          (duty),
		.volume        (volume),
		.wave_out      (wave_out)
	);

endmodule

`default_nettype wire

/* src/sq_regs.sv */
`timescale 1ns/10ps
`default_nettype none

module sq_regs
(
	input  wire                            clk50mhz,
	input  wire                            rst_n,
	input  wire                            wb_cyc,
	input  wire                            wb_stb,
	input  wire                            wb_we,
	input  wire  [1:0]                     wb_adr,
	input  wire  [7:0]                     wb_dat_w,
	input  wire  [chip_pkg::VOL_W-1:0]     volume,
	input  wire                            env_active,
	output logic [7:0]                     wb_dat_r,
	output logic                           wb_ack,
	output logic [chip_pkg::NOTE_W-1:0]    target_note,
	output logic [1:0]                     fx_sel,
	output chip_pkg::fx_opt_u              fx_opt,
	output logic [1:0]                     duty,
	output logic [1:0]                     attack,
	output logic [1:0]                     decay,
	output logic [2:0]                     length,
	output logic                           key_on
);

	logic [chip_pkg::NOTE_W-1:0] note_r;
	logic [7:0]                  fx_r;     // opt | duty | sel
	logic [6:0]                  env_r;    // length | decay | attack
	logic                        req;
	logic                        wr_en;

	assign req   = wb_cyc & wb_stb & ~wb_ack;  // new cycle, not acked yet
	assign wr_en = req & wb_we;

	always_ff @(posedge clk50mhz)
	begin
		if (!rst_n)
		begin
			wb_ack <= 1'b0;
			key_on <= 1'b0;
			note_r <= '0;
			fx_r   <= '0;
			env_r  <= '0;
		end
		else
		begin
			wb_ack <= req;   // single cycle ack, drops while host still holds stb
			key_on <= wr_en && (wb_adr == chip_pkg::REG_NOTE);  // every note write retriggers
			if (wr_en)
			begin
				case (wb_adr)
					chip_pkg::REG_NOTE: note_r <= wb_dat_w[chip_pkg::NOTE_W-1:0];
					chip_pkg::REG_FX:   fx_r   <= wb_dat_w;
					chip_pkg::REG_ENV:  env_r  <= wb_dat_w[6:0];
					default:            ;   // status ignores writes
				endcase
			end
		end
	end

	// host holds adr until ack so a plain mux is stable for the ack cycle
	always_comb
	begin
		case (wb_adr)
			chip_pkg::REG_NOTE: wb_dat_r = {2'b00, note_r};
			chip_pkg::REG_FX:   wb_dat_r = fx_r;
			chip_pkg::REG_ENV:  wb_dat_r = {1'b0, env_r};
			default:            wb_dat_r = {env_active, 3'b000, volume};  // live status
		endcase
	end

	assign target_note = note_r;
	assign fx_sel      = fx_r[1:0];
	assign duty        = fx_r[3:2];
	assign fx_opt      = fx_r[7:4];
	assign attack      = env_r[1:0];
	assign decay       = env_r[3:2];
	assign length      = env_r[6:4];

endmodule

`default_nettype wire

/* src/tone_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module tone_gen
#(
	parameter int PRESCALE = 512   // clocks per step counter tick
)
(
	input  wire                                clk50mhz,
	input  wire                                rst_n,
	input  wire  [chip_pkg::NOTE_W-1:0]        play_note,
	input  wire  signed [chip_pkg::OFS_W-1:0]  period_offset,
	input  wire  [1:0]                         duty,
	input  wire  [chip_pkg::VOL_W-1:0]         volume,
	output logic [chip_pkg::VOL_W-1:0]         wave_out
);

	localparam int PRE_W = (PRESCALE > 1) ? $clog2(PRESCALE) : 1;

	logic [PRE_W-1:0]              pre_cnt;
	logic                          pre_tick;
	logic [chip_pkg::NOTE_W-1:0]   rem;        // note minus whole octaves
	logic [2:0]                    octave;
	logic [3:0]                    semitone;
	logic [chip_pkg::PER_W-1:0]    base_per;
	logic [chip_pkg::PER_W-1:0]    step_len;   // next step length
	logic [chip_pkg::PER_W-1:0]    cur_len;    // length of the running step
	logic [chip_pkg::PER_W-1:0]    step_cnt;
	logic [2:0]                    step_idx;   // 8 step sequencer position
	logic [3:0]                    duty_thr;   // steps held high

	// note / 12 by subtraction, 63 needs at most 5 rounds
	always_comb
	begin
		rem    = play_note;
		octave = 3'd0;
		for (int i = 0; i < 5; i++)
		begin
			if (rem >= chip_pkg::NOTE_W'(12))
			begin
				rem    = rem - chip_pkg::NOTE_W'(12);
				octave = octave + 3'd1;
			end
		end
	end

	assign semitone = rem[3:0];
	assign base_per = chip_pkg::PERIOD_BASE[semitone];
	// each octave halves the step, then the signed vibrato offset
	assign step_len = (base_per >> octave)
		+ {{(chip_pkg::PER_W-chip_pkg::OFS_W){period_offset[chip_pkg::OFS_W-1]}}, period_offset};

	assign pre_tick = (pre_cnt == PRE_W'(PRESCALE - 1));

	always_ff @(posedge clk50mhz)
	begin
		if (!rst_n)
			pre_cnt <= '0;
		else if (pre_tick)
			pre_cnt <= '0;
		else
			pre_cnt <= pre_cnt + 1'b1;
	end

	always_ff @(posedge clk50mhz)
	begin
		if (!rst_n)
		begin
			step_cnt <= '0;
			cur_len  <= '0;
			step_idx <= 3'd0;
		end
		else if (pre_tick)
		begin
			if (step_cnt + 1'b1 >= cur_len)
			begin
				step_cnt <= '0;
				cur_len  <= step_len;    // pitch changes land on a step boundary
				step_idx <= step_idx + 3'd1;
			end
			else
				step_cnt <= step_cnt + 1'b1;
		end
	end

	always_comb
	begin
		case (duty)
			2'd0:    duty_thr = 4'd1;  // 12.5%
			2'd1:    duty_thr = 4'd2;  // 25%
			2'd2:    duty_thr = 4'd4;  // 50%
			default: duty_thr = 4'd6;  // 75%
		endcase
	end

	// level follows the envelope directly, no extra delay
	assign wave_out = ({1'b0, step_idx} < duty_thr) ? volume : '0;

endmodule

`default_nettype wire
